/* Makefile */
# Verilator build and regression run of the beamformer testbench

SIM_DIR = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench and check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --top-module beamform_tb -f list.f \
		--Mdir $(SIM_DIR) -o beamform_sim
	-$(SIM_DIR)/beamform_sim > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -qF '*** TEST PASSED ***' $(LOG); then echo "simulation gave no result"; exit 1; fi

clean:
	rm -rf $(SIM_DIR) $(LOG)

/* list.f */
+incdir+logic
logic/dsp_sample_pkg.sv
logic/dsp_weight_pkg.sv
logic/stream_control.sv
logic/complex_weigher.sv
logic/channel_summer.sv
logic/beamform_top.sv
testbench/beamform_tb.sv

/* logic/beamform_cfg.svh */
/*
 * Build-time sizes for the four-antenna receive beamformer.
 * Included by the packages and by every RTL module that sizes its ports.
 */
`ifndef BEAMFORM_CFG_SVH
`define BEAMFORM_CFG_SVH

// antenna channels 00, 01, 20 and 21 are combined into one beam
`define BF_CHANNELS 4

// complex samples carried side by side in one beat
`define BF_LANES 8

// bits in the real or the imaginary component of one sample
`define BF_SAMPLE_WIDTH 16

// bits in the real or the imaginary component of a channel weight
`define BF_WEIGHT_WIDTH 8

// the weight is a Q0.7 fraction, so a product carries this many fraction bits
`define BF_WEIGHT_FRAC 7

// one bus word holds every lane of one component
`define BF_BEAT_WIDTH (`BF_LANES * `BF_SAMPLE_WIDTH)

`endif

/* logic/beamform_top.sv */
/*
 * Top level of the four-antenna receive beamformer.
 * Each channel's beat is weighted by its own complex weight, the four results
 * are summed lane by lane, and the combined beat leaves on one output stream.
 */
`default_nettype none
`include "beamform_cfg.svh"

module beamform_top
    import dsp_sample_pkg::*;
    import dsp_weight_pkg::*;
(
    input  logic clock,
    input  logic resetn,
    input  logic s_valid [`BF_CHANNELS],
    input  logic s_last  [`BF_CHANNELS],
    input  logic [`BF_BEAT_WIDTH-1:0] s_real [`BF_CHANNELS],
    input  logic [`BF_BEAT_WIDTH-1:0] s_imag [`BF_CHANNELS],
    input  weight_t weight_real [`BF_CHANNELS],
    input  weight_t weight_imag [`BF_CHANNELS],
    input  logic m_ready,
    output logic s_ready,
    output logic m_valid,
    output logic m_last,
    output logic [`BF_BEAT_WIDTH-1:0] m_real,
    output logic [`BF_BEAT_WIDTH-1:0] m_imag
);

    // accept strobe, and the enable that moves every pipeline level together
    logic load;
    logic advance;

    // weighted beats of each channel on their way to the summer
    beat_u w_real [`BF_CHANNELS];
    beat_u w_imag [`BF_CHANNELS];

    // handshake side, the datapath below only follows load and advance
    stream_control u_control (
        .clock   (clock),
        .resetn  (resetn),
        .s_valid (s_valid),
        .s_last  (s_last),
        .m_ready (m_ready),
        .s_ready (s_ready),
        .load    (load),
        .advance (advance),
        .m_valid (m_valid),
        .m_last  (m_last)
    );

    // one weigher per antenna channel, indexed 00, 01, 20, 21 in that order
    for (genvar c = 0; c < `BF_CHANNELS; c++) begin : g_channel
        complex_weigher u_weigher (
            .clock       (clock),
            .load        (load),
            .advance     (advance),
            .s_real      (s_real[c]),
            .s_imag      (s_imag[c]),
            .weight_real (weight_real[c]),
            .weight_imag (weight_imag[c]),
            .w_real      (w_real[c]),
            .w_imag      (w_imag[c])
        );
    end

    // the sum register is the last level, its contents are the output data
    channel_summer u_summer (
        .clock   (clock),
        .advance (advance),
        .w_real  (w_real),
        .w_imag  (w_imag),
        .m_real  (m_real),
        .m_imag  (m_imag)
    );

endmodule

`default_nettype wire

/* logic/channel_summer.sv */
/*
 * Lane-wise sum of the four weighted channel beats.
 * Its registers are the output data of the combined stream, and they hold
 * while the pipe is stalled.
 */
`default_nettype none
`include "beamform_cfg.svh"

module channel_summer
    import dsp_sample_pkg::*;
(
    input  logic clock,
    input  logic advance,
    input  beat_u w_real [`BF_CHANNELS],
    input  beat_u w_imag [`BF_CHANNELS],
    output logic [`BF_BEAT_WIDTH-1:0] m_real,
    output logic [`BF_BEAT_WIDTH-1:0] m_imag
);

    beat_u next_real;
    beat_u next_imag;
    beat_u sum_real;
    beat_u sum_imag;

    // each lane is summed at full width and then wrapped to a sample,
    // which gives the same result as a 16-bit adder chain
    always_comb begin : lane_adder
        lane_sum_t acc_real;
        lane_sum_t acc_imag;
        for (int k = 0; k < `BF_LANES; k++) begin
            acc_real = '0;
            acc_imag = '0;
            for (int c = 0; c < `BF_CHANNELS; c++) begin
                acc_real = lane_accumulate(acc_real, w_real[c].lane[k]);
                acc_imag = lane_accumulate(acc_imag, w_imag[c].lane[k]);
            end
            next_real.lane[k] = wrap_sample(acc_real);
            next_imag.lane[k] = wrap_sample(acc_imag);
        end
    end

    // these registers hold the beat presented on the output stream
    always_ff @(posedge clock) begin
        if (advance) begin
            sum_real <= next_real;
            sum_imag <= next_imag;
        end
    end

    assign m_real = sum_real.word;
    assign m_imag = sum_imag.word;

    // a beat held under back-pressure must not change before the sink takes it
    a_output_hold: assert property (@(posedge clock)
        !advance |=> $stable(m_real) && $stable(m_imag));

endmodule

`default_nettype wire

/* logic/complex_weigher.sv */
/*
 * Complex multiply of one channel's beat by that channel's weight.
 * Captures the beat and weight at accept, forms the four partial products per
 * lane, then combines and scales them back to 16-bit samples.
 */
`default_nettype none
`include "beamform_cfg.svh"

module complex_weigher
    import dsp_sample_pkg::*;
    import dsp_weight_pkg::*;
(
    input  logic clock,
    input  logic load,
    input  logic advance,
    input  logic [`BF_BEAT_WIDTH-1:0] s_real,
    input  logic [`BF_BEAT_WIDTH-1:0] s_imag,
    input  weight_t weight_real,
    input  weight_t weight_imag,
    output beat_u w_real,
    output beat_u w_imag
);

    // the accepted beat and the weight that was present when it was taken
    beat_u in_real;
    beat_u in_imag;
    weight_t weight_real_q;
    weight_t weight_imag_q;

    // stage 1 partial products, named by sample component then weight component
    product_t prod_rr [`BF_LANES];
    product_t prod_ii [`BF_LANES];
    product_t prod_ri [`BF_LANES];
    product_t prod_ir [`BF_LANES];

    // load only fires on an advancing cycle, so the capture never runs ahead of the pipe
    // the weight is held here, so a later weight change only affects later beats
    always_ff @(posedge clock) begin
        if (load) begin
            in_real.word  <= s_real;
            in_imag.word  <= s_imag;
            weight_real_q <= weight_real;
            weight_imag_q <= weight_imag;
        end
    end

    // stage 1 does the multiplies for every lane in parallel
    always_ff @(posedge clock) begin
        if (advance) begin
            for (int k = 0; k < `BF_LANES; k++) begin
                prod_rr[k] <= partial_product(in_real.lane[k], weight_real_q);
                prod_ii[k] <= partial_product(in_imag.lane[k], weight_imag_q);
                prod_ri[k] <= partial_product(in_real.lane[k], weight_imag_q);
                prod_ir[k] <= partial_product(in_imag.lane[k], weight_real_q);
            end
        end
    end

    // stage 2 forms (xr + j xi)(wr + j wi) and drops the fraction bits
    // the 25-bit product type holds either sum without overflow
    always_ff @(posedge clock) begin
        if (advance) begin
            for (int k = 0; k < `BF_LANES; k++) begin
                w_real.lane[k] <= scale_product(prod_rr[k] - prod_ii[k]);
                w_imag.lane[k] <= scale_product(prod_ri[k] + prod_ir[k]);
            end
        end
    end

    // the summer reads these lanes during a stall, so they must hold
    // for as long as the control keeps advance low
    a_stage2_hold: assert property (@(posedge clock)
        !advance |=> $stable(w_real) && $stable(w_imag));

endmodule

`default_nettype wire

/* logic/dsp_sample_pkg.sv */
/*
 * Sample-level types of the beamformer datapath.
 * A beat is seen either as the raw bus word or as its signed lanes, and the
 * lane helpers keep channel sums wrapping the way two's complement hardware does.
 */
`default_nettype none
`include "beamform_cfg.svh"

package dsp_sample_pkg;

    // one signed component of a complex sample
    typedef logic signed [`BF_SAMPLE_WIDTH-1:0] sample_t;

    // the same 128 bits read as the bus word or as separate lanes
    // lane 0 sits in the low bits, matching the order on the input stream
    typedef union packed {
        logic [`BF_BEAT_WIDTH-1:0] word;
        sample_t [`BF_LANES-1:0] lane;
    } beat_u;

    // a lane summed over every channel needs this many bits before it wraps
    localparam int LANE_SUM_WIDTH = `BF_SAMPLE_WIDTH + $clog2(`BF_CHANNELS);

    typedef logic signed [LANE_SUM_WIDTH-1:0] lane_sum_t;

    // adds one lane to a running sum, the lane is sign extended first
    function automatic lane_sum_t lane_accumulate(input lane_sum_t acc, input sample_t value);
        return acc + lane_sum_t'(value);
    endfunction

    // keeps only the low sample bits, so an overflowing sum wraps around
    function automatic sample_t wrap_sample(input lane_sum_t value);
        return value[`BF_SAMPLE_WIDTH-1:0];
    endfunction

endpackage

`default_nettype wire

/* logic/dsp_weight_pkg.sv */
/*
 * Weight and product types of the beamformer datapath.
 * Holds the per-lane multiply and the fixed-point scaling back to a sample,
 * both used by each channel's complex weigher.
 */
`default_nettype none
`include "beamform_cfg.svh"

package dsp_weight_pkg;

    import dsp_sample_pkg::*;

    // one signed component of a channel weight, a Q0.7 fraction
    typedef logic signed [`BF_WEIGHT_WIDTH-1:0] weight_t;

    // a single product needs sample plus weight bits
    // one more bit lets two products be added without overflow
    localparam int PRODUCT_WIDTH = `BF_SAMPLE_WIDTH + `BF_WEIGHT_WIDTH + 1;

    typedef logic signed [PRODUCT_WIDTH-1:0] product_t;

    // signed multiply of one sample component by one weight component
    // both operands are widened first so the full product is kept
    function automatic product_t partial_product(input sample_t sample, input weight_t weight);
        return product_t'(sample) * product_t'(weight);
    endfunction

    // drops the weight's fraction bits with an arithmetic shift, which is a floor
    // division by 128, and keeps the low sample bits so a large result wraps
    function automatic sample_t scale_product(input product_t value);
        product_t shifted;
        shifted = value >>> `BF_WEIGHT_FRAC;
        return shifted[`BF_SAMPLE_WIDTH-1:0];
    endfunction

endpackage

`default_nettype wire

/* logic/stream_control.sv */
/*
 * Handshake control for the beamformer pipeline.
 * Joins the four input channels behind one shared ready, and carries a valid
 * bit and the channel-00 last bit alongside the datapath registers so that the
 * whole pipe stalls together when the output is back-pressured.
 */
`default_nettype none
`include "beamform_cfg.svh"

module stream_control (
    input  logic clock,
    input  logic resetn,
    input  logic s_valid [`BF_CHANNELS],
    input  logic s_last  [`BF_CHANNELS],
    input  logic m_ready,
    output logic s_ready,
    output logic load,
    output logic advance,
    output logic m_valid,
    output logic m_last
);

    // register levels between accept and the output
    // input capture, two weigher stages and the summer
    localparam int DEPTH = 4;

    logic [`BF_CHANNELS-1:0] valid_bits;
    logic [`BF_CHANNELS-1:0] last_bits;
    logic [DEPTH-1:0] valid_pipe;
    logic [DEPTH-1:0] last_pipe;
    logic running;

    // gather the per-channel flags into vectors so they can be reduced
    always_comb begin
        for (int c = 0; c < `BF_CHANNELS; c++) begin
            valid_bits[c] = s_valid[c];
            last_bits[c]  = s_last[c];
        end
    end

    // the pipe moves when the output register is empty or is being drained
    // a full output with m_ready low freezes every level at once
    assign advance = !valid_pipe[DEPTH-1] || m_ready;

    // running stays low through reset and for one cycle after it,
    // which keeps the input side closed until the pipe is known empty
    always_ff @(posedge clock) begin
        if (!resetn) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    assign s_ready = running && advance;

    // a beat is taken only when every channel offers one in the same cycle
    assign load = s_ready && (&valid_bits);

    // valid and last walk the pipe in step with the data registers
    // last is masked with load so it never shows up on an empty slot
    always_ff @(posedge clock) begin
        if (!resetn) begin
            valid_pipe <= '0;
            last_pipe  <= '0;
        end else if (advance) begin
            valid_pipe <= {valid_pipe[DEPTH-2:0], load};
            last_pipe  <= {last_pipe[DEPTH-2:0], load && last_bits[0]};
        end
    end

    assign m_valid = valid_pipe[DEPTH-1];
    assign m_last  = last_pipe[DEPTH-1];

    // the channels are framed together, so a packet boundary is seen on all four at once
    a_last_agrees: assert property (@(posedge clock) disable iff (!resetn)
        load |-> (last_bits == '0) || (last_bits == '1));

    // an offered output beat must not change or vanish until it is taken
    a_hold_on_stall: assert property (@(posedge clock) disable iff (!resetn)
        m_valid && !m_ready |=> m_valid && $stable(m_last));

    // nothing may be accepted while reset is applied or on the cycle right after it
    a_ready_in_reset: assert property (@(posedge clock)
        !resetn |=> !s_ready);

endmodule

`default_nettype wire

/* testbench/beamform_tb.sv */
/*
 * Testbench of the four-antenna receive beamformer.
 * Drives random beats and weights into beamform_top, predicts every combined
 * beat with its own fixed-point model and checks the output stream against a queue.
 */
`default_nettype none
`include "beamform_cfg.svh"

module beamform_tb;

    localparam int WAIT_LIMIT = 200;
    localparam int MODE_NEGATE = 0;
    localparam int MODE_RANDOM = 1;

    logic clock;
    logic resetn;
    logic s_valid [`BF_CHANNELS];
    logic s_last [`BF_CHANNELS];
    logic [`BF_BEAT_WIDTH-1:0] s_real [`BF_CHANNELS];
    logic [`BF_BEAT_WIDTH-1:0] s_imag [`BF_CHANNELS];
    logic signed [`BF_WEIGHT_WIDTH-1:0] weight_real [`BF_CHANNELS];
    logic signed [`BF_WEIGHT_WIDTH-1:0] weight_imag [`BF_CHANNELS];
    logic m_ready;
    logic s_ready;
    logic m_valid;
    logic m_last;
    logic [`BF_BEAT_WIDTH-1:0] m_real;
    logic [`BF_BEAT_WIDTH-1:0] m_imag;

    int seed = 32'he2d9_dd66;
    int error_count = 0;
    int check_count = 0;
    int test_count = 0;
    int cycle_count = 0;
    bit timed_out = 1'b0;
    bit check_latency = 1'b0;

    // expected beats in accept order, with the edge count at which each was taken
    logic [`BF_BEAT_WIDTH-1:0] exp_real_q [$];
    logic [`BF_BEAT_WIDTH-1:0] exp_imag_q [$];
    logic exp_last_q [$];
    int accept_q [$];

    beamform_top i_dut (
        .clock       (clock),
        .resetn      (resetn),
        .s_valid     (s_valid),
        .s_last      (s_last),
        .s_real      (s_real),
        .s_imag      (s_imag),
        .weight_real (weight_real),
        .weight_imag (weight_imag),
        .m_ready     (m_ready),
        .s_ready     (s_ready),
        .m_valid     (m_valid),
        .m_last      (m_last),
        .m_real      (m_real),
        .m_imag      (m_imag)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic logic rand_flag(input int percent);
        logic [31:0] w;
        w = $random(seed);
        return (w % 32'd100) < 32'(percent);
    endfunction

    function automatic logic [`BF_BEAT_WIDTH-1:0] rand_beat();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    function automatic logic all_valid();
        logic ok;
        ok = 1'b1;
        for (int c = 0; c < `BF_CHANNELS; c++) begin
            ok = ok && s_valid[c];
        end
        return ok;
    endfunction

    // integer division rounds toward zero, so negative remainders step down once more
    function automatic int floor_div(input int value, input int divisor);
        int q;
        q = value / divisor;
        if ((value % divisor != 0) && (value < 0)) begin
            q = q - 1;
        end
        return q;
    endfunction

    function automatic logic signed [15:0] wrap16(input int value);
        return value[15:0];
    endfunction

    // expected combined beat for the inputs present at this accept
    function automatic void model_beat(output logic [`BF_BEAT_WIDTH-1:0] exp_real,
                                       output logic [`BF_BEAT_WIDTH-1:0] exp_imag);
        int acc_r;
        int acc_i;
        int xr;
        int xi;
        int wr;
        int wi;
        for (int k = 0; k < `BF_LANES; k++) begin
            acc_r = 0;
            acc_i = 0;
            for (int c = 0; c < `BF_CHANNELS; c++) begin
                xr = int'($signed(s_real[c][k*16 +: 16]));
                xi = int'($signed(s_imag[c][k*16 +: 16]));
                wr = int'(weight_real[c]);
                wi = int'(weight_imag[c]);
                acc_r += int'(wrap16(floor_div(xr * wr - xi * wi, 128)));
                acc_i += int'(wrap16(floor_div(xr * wi + xi * wr, 128)));
            end
            exp_real[k*16 +: 16] = acc_r[15:0];
            exp_imag[k*16 +: 16] = acc_i[15:0];
        end
    endfunction

    task automatic report_timeout(input string what);
        $display("timeout: %0s", what);
        error_count++;
        timed_out = 1'b1;
    endtask

    // a new beat for every channel, all channels share the same last flag
    task automatic present_beat(input int mode, input logic last);
        logic [`BF_BEAT_WIDTH-1:0] word;
        for (int c = 0; c < `BF_CHANNELS; c++) begin
            word = rand_beat();
            // the most negative sample has no positive twin and must wrap
            if (mode == MODE_NEGATE && c == 0) begin
                word[15:0] = 16'h8000;
            end
            s_real[c] <= word;
            s_imag[c] <= rand_beat();
            s_last[c] <= last;
            if (mode == MODE_NEGATE) begin
                weight_real[c] <= (c == 0) ? 8'sh80 : 8'sh00;
                weight_imag[c] <= 8'sh00;
            end else begin
                weight_real[c] <= 8'($random(seed));
                weight_imag[c] <= 8'($random(seed));
            end
        end
    endtask

    task automatic drive_valids(input int percent);
        for (int c = 0; c < `BF_CHANNELS; c++) begin
            s_valid[c] <= rand_flag(percent);
        end
    endtask

    // offers count beats, each held until the DUT takes it
    task automatic stream_beats(input int count, input int mode, input int valid_pct,
                                input int ready_pct, input int last_every);
        int sent;
        int idle;
        sent = 0;
        idle = 0;
        @(posedge clock);
        present_beat(mode, last_every == 1);
        drive_valids(valid_pct);
        m_ready <= rand_flag(ready_pct);
        while (sent < count && !timed_out) begin
            @(posedge clock);
            if (s_ready && all_valid()) begin
                sent++;
                idle = 0;
                if (sent < count) begin
                    present_beat(mode, (sent % last_every) == last_every - 1);
                end
            end else begin
                idle++;
                if (idle > WAIT_LIMIT) begin
                    report_timeout("input beat was never accepted");
                end
            end
            if (sent < count) begin
                drive_valids(valid_pct);
            end else begin
                drive_valids(0);
            end
            m_ready <= rand_flag(ready_pct);
        end
    endtask

    task automatic drain_output();
        int waited;
        waited = 0;
        @(posedge clock);
        m_ready <= 1'b1;
        @(negedge clock);
        while (exp_real_q.size() != 0 && !timed_out) begin
            @(negedge clock);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("expected beats never left the output");
            end
        end
    endtask

    task automatic check_reset_outputs(input logic ready_expected);
        check_count++;
        assert (m_valid == 1'b0) else begin
            error_count++;
            $display("MISMATCH m_valid: expected %h, got %h", 1'b0, m_valid);
        end
        assert (m_last == 1'b0) else begin
            error_count++;
            $display("MISMATCH m_last: expected %h, got %h", 1'b0, m_last);
        end
        assert (s_ready == ready_expected) else begin
            error_count++;
            $display("MISMATCH s_ready: expected %h, got %h", ready_expected, s_ready);
        end
    endtask

    task automatic end_test(input string name, input int start_errors);
        test_count++;
        $display("test %0s finished with %0d errors", name, error_count - start_errors);
    endtask

    // scoreboard, all values read here are the ones the DUT saw at this edge
    always @(posedge clock) begin : scoreboard
        logic [`BF_BEAT_WIDTH-1:0] er;
        logic [`BF_BEAT_WIDTH-1:0] ei;
        logic el;
        int taken;
        cycle_count = cycle_count + 1;
        if (resetn) begin
            if (s_ready && all_valid()) begin
                model_beat(er, ei);
                exp_real_q.push_back(er);
                exp_imag_q.push_back(ei);
                exp_last_q.push_back(s_last[0]);
                accept_q.push_back(cycle_count);
            end
            if (m_valid && m_ready) begin
                check_count++;
                if (exp_real_q.size() == 0) begin
                    error_count++;
                    $display("output beat appeared with no accepted beat left to match it");
                end else begin
                    er = exp_real_q.pop_front();
                    ei = exp_imag_q.pop_front();
                    el = exp_last_q.pop_front();
                    taken = accept_q.pop_front();
                    assert (m_real == er) else begin
                        error_count++;
                        $display("MISMATCH m_real: expected %h, got %h", er, m_real);
                    end
                    assert (m_imag == ei) else begin
                        error_count++;
                        $display("MISMATCH m_imag: expected %h, got %h", ei, m_imag);
                    end
                    assert (m_last == el) else begin
                        error_count++;
                        $display("MISMATCH m_last: expected %h, got %h", el, m_last);
                    end
                    // taken at edge N, valid after edge N+3, so it leaves at edge N+4
                    assert (!check_latency || cycle_count - taken == 4) else begin
                        error_count++;
                        $display("output beat left %0d cycles after accept instead of 4",
                                 cycle_count - taken);
                    end
                end
            end
        end
    end

    // a stalled output beat keeps its valid, last and data until the sink takes it
    a_output_held: assert property (@(posedge clock) disable iff (!resetn)
        m_valid && !m_ready |=> m_valid && $stable(m_last) && $stable(m_real)
            && $stable(m_imag))
        else begin
            error_count++;
            $display("output beat changed or vanished while the sink was stalling");
        end

    initial begin : main
        int start;
        resetn = 1'b0;
        m_ready = 1'b0;
        for (int c = 0; c < `BF_CHANNELS; c++) begin
            s_valid[c] = 1'b0;
            s_last[c] = 1'b0;
            s_real[c] = '0;
            s_imag[c] = '0;
            weight_real[c] = '0;
            weight_imag[c] = '0;
        end

        // reset is held for ten edges, the last check falls on the first free cycle
        start = error_count;
        for (int i = 0; i < 10; i++) begin
            @(posedge clock);
            if (i == 9) begin
                resetn <= 1'b1;
            end
            @(negedge clock);
            check_reset_outputs(1'b0);
        end
        @(negedge clock);
        check_reset_outputs(1'b1);
        end_test("reset", start);

        start = error_count;
        check_latency = 1'b1;
        stream_beats(20, MODE_NEGATE, 100, 100, 4);
        drain_output();
        end_test("exact negation", start);

        start = error_count;
        stream_beats(60, MODE_RANDOM, 100, 100, 4);
        drain_output();
        check_latency = 1'b0;
        end_test("random beamforming", start);

        start = error_count;
        stream_beats(80, MODE_RANDOM, 100, 50, 5);
        drain_output();
        end_test("back-pressure", start);

        start = error_count;
        stream_beats(60, MODE_RANDOM, 60, 70, 3);
        drain_output();
        end_test("join and last", start);

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
